// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_tama_lcd
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: clk_en_gen.sv
module clk_en_gen (
  input  logic clk,
  input  logic arst_n,
  output logic clk_en_cpu,
  output logic clk_en_2x
);
  import tama_pkg::*;

  logic [DIV_CNT_W-1:0] div_cnt;

  // Count down from the reload value, pulse at zero and at the midpoint
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt    <= DIV_CNT_W'(DIV_RELOAD);
      clk_en_cpu <= 1'b0;
      clk_en_2x  <= 1'b0;
    end else begin
      clk_en_cpu <= 1'b0;
      clk_en_2x  <= 1'b0;
      if (div_cnt == '0) begin
        div_cnt    <= DIV_CNT_W'(DIV_RELOAD);
        clk_en_cpu <= 1'b1;
        clk_en_2x  <= 1'b1;
      end else begin
        div_cnt <= div_cnt - 1'b1;
        if (div_cnt == DIV_CNT_W'(DIV_HALF)) begin
          clk_en_2x <= 1'b1; // Extra pulse halfway through the CPU period
        end
      end
    end
  end

  // The 2x enable is a superset of the CPU step enable
  a_cpu_in_2x : assert property (
    @(posedge clk) disable iff (!arst_n)
    clk_en_cpu |-> clk_en_2x
  ) else $error("clk_en_cpu pulsed without clk_en_2x");

endmodule

// File: lcd_ram.sv
module lcd_ram (
  input  logic                            clk,
  input  logic                            cpu_clk_en,
  input  logic                            we,
  input  logic [tama_pkg::LCD_ADDR_W-1:0] wr_addr,
  input  logic [tama_pkg::LCD_DATA_W-1:0] wr_data,
  input  logic [tama_pkg::LCD_ADDR_W-1:0] rd_addr,
  output logic [tama_pkg::LCD_DATA_W-1:0] rd_data
);
  import tama_pkg::*;

  // Four dots per word, bit n holds dot 4*addr+n
  logic [LCD_DATA_W-1:0] mem [LCD_WORDS];

  // The emulated CPU only writes on its own step edges
  always_ff @(posedge clk) begin
    if (we && cpu_clk_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr]; // Video read port
  end

  // Once the divider is out of reset the write strobe must be a clean level
  a_we_known : assert property (
    @(posedge clk)
    !$isunknown(cpu_clk_en) |-> !$isunknown(we)
  ) else $error("lcd_ram write enable is unknown");

endmodule

// File: lcd_renderer.sv
module lcd_renderer (
  input  logic                            clk,
  input  logic                            arst_n,
  video_if.sink                           vid,
  output logic [tama_pkg::LCD_ADDR_W-1:0] rd_addr,
  input  logic [tama_pkg::LCD_DATA_W-1:0] rd_data,
  input  logic                            all_off,
  input  logic                            all_on,
  output logic                            de_out,
  output logic                            hsync_out,
  output logic                            vsync_out,
  output logic [23:0]                     rgb
);
  import tama_pkg::*;

  logic [X_W-1:0]       dot_col;
  logic [Y_W-1:0]       dot_row;
  logic [DOT_IDX_W-1:0] dot_idx;
  logic [DOT_BIT_W-1:0] bit_sel;
  logic [DOT_BIT_W-1:0] bit_sel_q;
  logic                 de_q;
  logic                 hsync_q;
  logic                 vsync_q;
  logic                 dot_on;
  logic [23:0]          rgb_next;

  // Stage one: scan position to dot, word address goes straight to the RAM
  always_comb begin
    dot_col = vid.x / X_W'(DOT_SCALE);
    dot_row = vid.y / Y_W'(DOT_SCALE);
    dot_idx = DOT_IDX_W'(dot_row * LCD_COLS + dot_col); // Wraps in blanking, masked by de
    rd_addr = LCD_ADDR_W'(dot_idx / DOTS_PER_WORD);
    bit_sel = DOT_BIT_W'(dot_idx % DOTS_PER_WORD);
  end

  // Bit select travels alongside the RAM read
  always_ff @(posedge clk) begin
    bit_sel_q <= bit_sel;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      de_q    <= 1'b0;
      hsync_q <= 1'b0;
      vsync_q <= 1'b0;
    end else begin
      de_q    <= vid.de;
      hsync_q <= vid.hsync;
      vsync_q <= vid.vsync;
    end
  end

  // Stage two: pick the dot and colour it
  assign dot_on = rd_data[bit_sel_q];

  always_comb begin
    if (!de_q) begin
      rgb_next = '0;
    end else if (all_off) begin
      rgb_next = RGB_DOT_OFF; // Blank segment test wins over all-on
    end else if (all_on) begin
      rgb_next = RGB_DOT_ON;
    end else if (dot_on) begin
      rgb_next = RGB_DOT_ON;
    end else begin
      rgb_next = RGB_DOT_OFF;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      de_out    <= 1'b0;
      hsync_out <= 1'b0;
      vsync_out <= 1'b0;
      rgb       <= '0;
    end else begin
      de_out    <= de_q;
      hsync_out <= hsync_q;
      vsync_out <= vsync_q;
      rgb       <= rgb_next;
    end
  end

  // Pixel data is black outside the active window
  a_rgb_blank : assert property (
    @(posedge clk) disable iff (!arst_n)
    !de_out |-> (rgb == '0)
  ) else $error("rgb not zero outside de");

endmodule

// File: sources.f
tama_pkg.sv
video_if.sv
clk_en_gen.sv
lcd_ram.sv
video_timing.sv
lcd_renderer.sv
tama_lcd_top.sv
tb_tama_lcd.sv

// File: tama_lcd_top.sv
module tama_lcd_top (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            lcd_we,
  input  logic [tama_pkg::LCD_ADDR_W-1:0] lcd_waddr,
  input  logic [tama_pkg::LCD_DATA_W-1:0] lcd_wdata,
  input  logic                            lcd_all_off_setting,
  input  logic                            lcd_all_on_setting,
  output logic                            clk_en_cpu,
  output logic                            clk_en_2x,
  output logic                            de,
  output logic                            hsync,
  output logic                            vsync,
  output logic [23:0]                     rgb
);
  import tama_pkg::*;

  logic [LCD_ADDR_W-1:0] rd_addr;
  logic [LCD_DATA_W-1:0] rd_data;

  video_if vid ();

  clk_en_gen u_clk_en_gen (
    .clk        (clk),
    .arst_n     (arst_n),
    .clk_en_cpu (clk_en_cpu),
    .clk_en_2x  (clk_en_2x)
  );

  // Write port stands in for the emulated CPU
  lcd_ram u_lcd_ram (
    .clk        (clk),
    .cpu_clk_en (clk_en_cpu),
    .we         (lcd_we),
    .wr_addr    (lcd_waddr),
    .wr_data    (lcd_wdata),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  video_timing u_video_timing (
    .clk    (clk),
    .arst_n (arst_n),
    .vid    (vid.source)
  );

  lcd_renderer u_lcd_renderer (
    .clk       (clk),
    .arst_n    (arst_n),
    .vid       (vid.sink),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .all_off   (lcd_all_off_setting),
    .all_on    (lcd_all_on_setting),
    .de_out    (de),
    .hsync_out (hsync),
    .vsync_out (vsync),
    .rgb       (rgb)
  );

endmodule

// File: tama_pkg.sv
package tama_pkg;

  // CPU step divider, one step every DIV_RELOAD+1 cycles of clk
  localparam int DIV_RELOAD = 100;
  localparam int DIV_HALF   = 50;
  localparam int DIV_CNT_W  = $clog2(DIV_RELOAD + 1);

  // Dot matrix of the pet LCD
  localparam int LCD_COLS      = 32;
  localparam int LCD_ROWS      = 16;
  localparam int DOTS_PER_WORD = 4;
  localparam int LCD_ADDR_W    = 7;
  localparam int LCD_DATA_W    = 4;
  localparam int LCD_WORDS     = 2 ** LCD_ADDR_W;
  localparam int DOT_IDX_W     = $clog2(LCD_COLS * LCD_ROWS);
  localparam int DOT_BIT_W     = $clog2(DOTS_PER_WORD);

  localparam int DOT_SCALE = 4; // Pixels per dot in x and in y

  // Horizontal timing in clk cycles
  localparam int H_ACTIVE = 128;
  localparam int H_FP     = 4;
  localparam int H_SYNC   = 8;
  localparam int H_BP     = 8;
  localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;

  // Vertical timing in lines
  localparam int V_ACTIVE = 64;
  localparam int V_FP     = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BP     = 4;
  localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

  localparam int X_W = 8;
  localparam int Y_W = 7;

  localparam logic [23:0] RGB_DOT_ON  = 24'h10_18_10; // Dark segment
  localparam logic [23:0] RGB_DOT_OFF = 24'hB0_C8_A0; // Pale LCD background

endpackage

// File: tb_tama_lcd.sv
module tb_tama_lcd;
  import tama_pkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int CPU_PERIOD    = DIV_RELOAD + 1;
  localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;
  localparam int WATCHDOG_TIME = 8 * FRAME_CYCLES * CLK_PERIOD +
                                 140 * CPU_PERIOD * CLK_PERIOD;

  logic                  clk;
  logic                  arst_n;
  logic                  lcd_we;
  logic [LCD_ADDR_W-1:0] lcd_waddr;
  logic [LCD_DATA_W-1:0] lcd_wdata;
  logic                  lcd_all_off_setting;
  logic                  lcd_all_on_setting;
  logic                  clk_en_cpu;
  logic                  clk_en_2x;
  logic                  de;
  logic                  hsync;
  logic                  vsync;
  logic [23:0]           rgb;

  logic [LCD_DATA_W-1:0] dot_model [LCD_WORDS]; // Expected contents of the dot memory
  logic [LCD_ADDR_W-1:0] target;
  logic [23:0]           exp_rgb;
  int                    seed;
  int                    word_idx;
  int                    gap_exp;
  bit                    px_check;

  // Monitor state is counted in clk cycles after reset
  int cyc          = 0;
  int last_cpu     = -1;
  int last_2x      = -1;
  int last_gap     = DIV_HALF + 1; // First 2x gap after reset is the short one
  int last_hs_rise = -1;
  int hs_lines     = 0;
  int vs_rise      = -1;
  int px           = 0;
  int py           = 0;
  bit armed        = 1'b0;
  bit de_prev      = 1'b0;
  bit hs_prev      = 1'b0;
  bit vs_prev      = 1'b0;

  tama_lcd_top dut0 (
    .clk                 (clk),
    .arst_n              (arst_n),
    .lcd_we              (lcd_we),
    .lcd_waddr           (lcd_waddr),
    .lcd_wdata           (lcd_wdata),
    .lcd_all_off_setting (lcd_all_off_setting),
    .lcd_all_on_setting  (lcd_all_on_setting),
    .clk_en_cpu          (clk_en_cpu),
    .clk_en_2x           (clk_en_2x),
    .de                  (de),
    .hsync               (hsync),
    .vsync               (vsync),
    .rgb                 (rgb)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic error_abort(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "testbench stopped at first error");
  endtask

  task automatic mismatch_abort(input string name, input longint expected, input longint actual);
    error_abort($sformatf("mismatch at %0t: %s expected 0x%0h got 0x%0h",
                          $time, name, expected, actual));
  endtask

  // Colour of a pixel from the dot model and the two settings
  function automatic logic [23:0] pixel_color(input int col, input int row);
    int                    idx;
    logic [LCD_DATA_W-1:0] dots;
    idx  = (row / DOT_SCALE) * LCD_COLS + col / DOT_SCALE;
    dots = dot_model[idx / DOTS_PER_WORD];
    if (lcd_all_off_setting) return RGB_DOT_OFF;
    if (lcd_all_on_setting) return RGB_DOT_ON;
    return dots[idx % DOTS_PER_WORD] ? RGB_DOT_ON : RGB_DOT_OFF;
  endfunction

  // Called 1 unit after an edge, so clk_en_cpu already shows the value for the next edge
  task automatic cpu_write(input logic [LCD_ADDR_W-1:0] addr, input logic [LCD_DATA_W-1:0] data);
    lcd_waddr = addr;
    lcd_wdata = data;
    lcd_we    = 1'b1;
    while (!clk_en_cpu) begin
      @(posedge clk);
      #1;
    end
    dot_model[addr] = data;
    @(posedge clk);
    #1;
    lcd_we = 1'b0;
  endtask

  // The RAM must ignore a one cycle strobe outside an enable
  task automatic stray_write(input logic [LCD_ADDR_W-1:0] addr, input logic [LCD_DATA_W-1:0] data);
    while (clk_en_cpu) begin
      @(posedge clk);
      #1;
    end
    lcd_waddr = addr;
    lcd_wdata = data;
    lcd_we    = 1'b1;
    @(posedge clk);
    #1;
    lcd_we = 1'b0;
  endtask

  task automatic wait_frame_start();
    @(posedge vsync);
    #1;
  endtask

  // Outputs settle after the rising edge, so everything is sampled on the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      cyc = cyc + 1;

      if (clk_en_cpu) begin
        assert (clk_en_2x) else error_abort("clk_en_cpu pulsed while clk_en_2x was low");
        if (last_cpu >= 0) begin
          assert (cyc - last_cpu == CPU_PERIOD)
            else mismatch_abort("clk_en_cpu period", CPU_PERIOD, cyc - last_cpu);
        end
        last_cpu = cyc;
      end
      if (clk_en_2x) begin
        if (last_2x >= 0) begin
          gap_exp = (last_gap == DIV_HALF + 1) ? DIV_HALF : DIV_HALF + 1;
          assert (cyc - last_2x == gap_exp)
            else mismatch_abort("clk_en_2x spacing", gap_exp, cyc - last_2x);
          last_gap = cyc - last_2x;
        end
        last_2x = cyc;
      end

      assert (!(hsync && de)) else error_abort("hsync was high during active video");
      if (hsync && !hs_prev) begin
        if (last_hs_rise >= 0) begin
          assert (cyc - last_hs_rise == H_TOTAL)
            else mismatch_abort("hsync period", H_TOTAL, cyc - last_hs_rise);
        end
        last_hs_rise = cyc;
        hs_lines     = hs_lines + 1;
      end
      if (!hsync && hs_prev) begin
        assert (cyc - last_hs_rise == H_SYNC)
          else mismatch_abort("hsync width", H_SYNC, cyc - last_hs_rise);
      end

      // The frame before the first vsync is partial, so line checks start there
      if (vsync && !vs_prev) begin
        if (armed) begin
          assert (py == V_ACTIVE) else mismatch_abort("de lines per frame", V_ACTIVE, py);
          assert (hs_lines == V_TOTAL)
            else mismatch_abort("hsync pulses per frame", V_TOTAL, hs_lines);
        end
        armed    = 1'b1;
        py       = 0;
        hs_lines = 0;
        vs_rise  = cyc;
      end
      if (!vsync && vs_prev) begin
        assert (cyc - vs_rise == V_SYNC * H_TOTAL)
          else mismatch_abort("vsync width", V_SYNC * H_TOTAL, cyc - vs_rise);
      end

      if (de) begin
        if (armed && px_check) begin
          exp_rgb = pixel_color(px, py);
          assert (rgb == exp_rgb) else mismatch_abort("rgb", exp_rgb, rgb);
        end
        px = px + 1;
      end else begin
        assert (rgb == '0) else mismatch_abort("rgb outside de", 0, rgb);
      end
      if (!de && de_prev) begin
        if (armed) begin
          assert (px == H_ACTIVE) else mismatch_abort("de cycles per line", H_ACTIVE, px);
        end
        px = 0;
        py = py + 1;
      end

      de_prev = de;
      hs_prev = hsync;
      vs_prev = vsync;
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    error_abort("watchdog expired before the test sequence finished");
  end

  initial begin
    seed                = 32'h2970_3de9;
    arst_n              = 1'b0;
    lcd_we              = 1'b0;
    lcd_waddr           = '0;
    lcd_wdata           = '0;
    lcd_all_off_setting = 1'b0;
    lcd_all_on_setting  = 1'b0;
    px_check            = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;

    for (word_idx = 0; word_idx < LCD_WORDS; word_idx++) begin
      cpu_write(LCD_ADDR_W'(word_idx), LCD_DATA_W'($random(seed)));
    end

    wait_frame_start();
    px_check = 1'b1;
    wait_frame_start(); // Settings start after one frame of plain dot content
    lcd_all_on_setting = 1'b1;
    wait_frame_start();
    lcd_all_on_setting  = 1'b0;
    lcd_all_off_setting = 1'b1;
    wait_frame_start();
    lcd_all_on_setting = 1'b1; // Off has priority when both are set
    wait_frame_start();
    lcd_all_on_setting  = 1'b0;
    lcd_all_off_setting = 1'b0;

    target = LCD_ADDR_W'($random(seed));
    stray_write(target, ~dot_model[target]);
    wait_frame_start();

    // Lands in vertical blanking, so the whole next active area shows it
    target = LCD_ADDR_W'($random(seed));
    cpu_write(target, ~dot_model[target]);
    wait_frame_start();

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: video_if.sv
interface video_if;
  import tama_pkg::*;

  logic [X_W-1:0] x; // Pixel column
  logic [Y_W-1:0] y; // Line
  logic           de;
  logic           hsync;
  logic           vsync;

  // Timing generator side
  modport source (
    output x,
    output y,
    output de,
    output hsync,
    output vsync
  );

  // Renderer side
  modport sink (
    input x,
    input y,
    input de,
    input hsync,
    input vsync
  );

endinterface

// File: video_timing.sv
module video_timing (
  input logic     clk,
  input logic     arst_n,
  video_if.source vid
);
  import tama_pkg::*;

  logic [X_W-1:0] h_cnt;
  logic [X_W-1:0] h_next;
  logic [Y_W-1:0] v_cnt;
  logic [Y_W-1:0] v_next;
  logic           de_r;
  logic           hsync_r;
  logic           vsync_r;

  always_comb begin
    h_next = h_cnt + 1'b1;
    v_next = v_cnt;
    if (h_cnt == X_W'(H_TOTAL - 1)) begin
      h_next = '0;
      if (v_cnt == Y_W'(V_TOTAL - 1)) begin
        v_next = '0;
      end else begin
        v_next = v_cnt + 1'b1;
      end
    end
  end

  // Flags are decoded from the next position so they line up with the counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_cnt   <= '0;
      v_cnt   <= '0;
      de_r    <= 1'b0;
      hsync_r <= 1'b0;
      vsync_r <= 1'b0;
    end else begin
      h_cnt   <= h_next;
      v_cnt   <= v_next;
      de_r    <= (h_next < X_W'(H_ACTIVE)) && (v_next < Y_W'(V_ACTIVE));
      hsync_r <= (h_next >= X_W'(H_ACTIVE + H_FP)) &&
                 (h_next < X_W'(H_ACTIVE + H_FP + H_SYNC));
      vsync_r <= (v_next >= Y_W'(V_ACTIVE + V_FP)) &&
                 (v_next < Y_W'(V_ACTIVE + V_FP + V_SYNC)); // Whole lines
    end
  end

  assign vid.x     = h_cnt;
  assign vid.y     = v_cnt;
  assign vid.de    = de_r;
  assign vid.hsync = hsync_r;
  assign vid.vsync = vsync_r;

  // Sync pulse sits in the blanking interval
  a_hsync_blank : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(vid.hsync && vid.de)
  ) else $error("hsync asserted during active video");

endmodule
